// ==== common/counter_pkg.sv ====
// Shared constants and types for the push-button counter
// Timing values are scaled down so simulation stays short

`default_nettype none

package counter_pkg;

    // ----------------------------------------------------------------------
    // Timing
    // ----------------------------------------------------------------------
    localparam int CLKS_PER_BIT    = 16;   // Serial bit period in clocks
    localparam int DEBOUNCE_CYCLES = 4;    // Cycles a new level must hold
    localparam int CYCLES_PER_MS   = 8;    // Scaled millisecond

    // ----------------------------------------------------------------------
    // Widths and types
    // ----------------------------------------------------------------------
    localparam int COUNT_W = 16;

    typedef logic [COUNT_W-1:0] press_count_t;  // Wraps at limit
    typedef logic [7:0]         byte_t;         // One serial byte
    typedef logic [31:0]        cycles_t;       // Duration, cycles or ms

    // ASCII codes seen by the command parser
    localparam byte_t CHAR_A     = 8'h41;
    localparam byte_t CHAR_C     = 8'h43;
    localparam byte_t CHAR_K     = 8'h4B;
    localparam byte_t CHAR_SPACE = 8'h20;
    localparam byte_t CHAR_ZERO  = 8'h30;
    localparam byte_t CHAR_NINE  = 8'h39;
    localparam byte_t CHAR_LF    = 8'h0A;

    // Parser states, named after the last byte matched
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_A,
        ST_C,
        ST_K,
        ST_SPACE,
        ST_NUM
    } ack_state_t;

endpackage

`default_nettype wire

// ==== hw/button/button_counter.sv ====
// Button path: synchronizer, debouncer, press pulse and press count
// Active-high bouncing button in, one pulse per clean press out

`timescale 1ns/1ns
`default_nettype none

module button_counter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      btn,          // Async, bouncing
    output logic                      btn_level,    // Debounced level
    output logic                      btn_pulse,    // One cycle per press
    output counter_pkg::press_count_t press_count
);
    import counter_pkg::*;

    typedef logic [$clog2(DEBOUNCE_CYCLES)-1:0] db_count_t;

    logic [1:0] btn_sync;   // Two-flop synchronizer
    logic       btn_s;
    db_count_t  db_count;   // Cycles the input has differed

    assign btn_s = btn_sync[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            btn_sync <= 2'b00;
        end else begin
            btn_sync <= {btn_sync[0], btn};
        end
    end

    // ----------------------------------------------------------------------
    // Debounce and rising-level pulse
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            db_count  <= '0;
            btn_level <= 1'b0;
            btn_pulse <= 1'b0;
        end else begin
            btn_pulse <= 1'b0;                  // Default low
            if (btn_s == btn_level) begin
                db_count <= '0;                 // Glitch over, start again
            end else if (db_count == db_count_t'(DEBOUNCE_CYCLES - 1)) begin
                btn_level <= btn_s;             // Held long enough
                db_count  <= '0;
                btn_pulse <= btn_s;             // Only on press, not release
            end else begin
                db_count <= db_count + 1'b1;
            end
        end
    end

    // Count lags the pulse by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            press_count <= '0;
        end else if (btn_pulse) begin
            press_count <= press_count + 1'b1;  // Wraps at limit
        end
    end

endmodule

`default_nettype wire

// ==== hw/uart/uart_rx.sv ====
// Serial receiver, 8N1 at a fixed bit period
// Mid-bit sampling, LSB first, stop bit not checked

`timescale 1ns/1ns
`default_nettype none

module uart_rx (
    input  logic               clk,
    input  logic               rst,
    input  logic               rx,        // Idles high
    output counter_pkg::byte_t rx_data,   // Held until next byte
    output logic               rx_valid   // One-cycle strobe
);
    import counter_pkg::*;

    typedef logic [$clog2(CLKS_PER_BIT)-1:0] bit_timer_t;

    logic [2:0] rx_sync;    // Three-flop synchronizer
    logic       rx_line;
    logic       busy;       // Frame in progress
    bit_timer_t bit_timer;  // Cycles to next sample point
    logic       bit_tick;
    logic [3:0] bit_idx;    // 0 start, 1..8 data, 9 stop
    byte_t      shift_reg;

    assign rx_line  = rx_sync[2];
    assign bit_tick = (bit_timer == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_sync <= 3'b111;  // Line idles high
        end else begin
            rx_sync <= {rx_sync[1:0], rx};
        end
    end

    // ----------------------------------------------------------------------
    // Frame control
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            bit_timer <= '0;
            bit_idx   <= '0;
            rx_valid  <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!busy) begin
                // Line low while idle marks the start edge
                if (!rx_line) begin
                    busy      <= 1'b1;
                    bit_timer <= bit_timer_t'(CLKS_PER_BIT / 2 - 1);  // Mid start bit
                    bit_idx   <= '0;
                end
            end else if (bit_tick) begin
                bit_timer <= bit_timer_t'(CLKS_PER_BIT - 1);          // Full period
                bit_idx   <= bit_idx + 1'b1;
                if (bit_idx == 4'd9) begin
                    rx_valid <= 1'b1;   // Stop-bit sample
                    busy     <= 1'b0;
                end
            end else begin
                bit_timer <= bit_timer - 1'b1;
            end
        end
    end

    // Data bits shift in from the top, LSB arrives first
    always_ff @(posedge clk) begin
        if (busy && bit_tick) begin
            if (bit_idx != 4'd0 && bit_idx != 4'd9) begin
                shift_reg <= {rx_line, shift_reg[7:1]};
            end
            if (bit_idx == 4'd9) begin
                rx_data <= shift_reg;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/ack_parser.sv ====
// ACK command parser
// Matches "ACK <ms>\n" byte by byte and converts ms into LED cycles

`timescale 1ns/1ns
`default_nettype none

module ack_parser (
    input  logic                 clk,
    input  logic                 rst,
    input  counter_pkg::byte_t   rx_data,
    input  logic                 rx_valid,
    output logic                 ack_trigger,  // One cycle after the LF
    output counter_pkg::cycles_t led_cycles    // Valid with ack_trigger
);
    import counter_pkg::*;

    ack_state_t state;
    cycles_t    ms_value;   // Decimal accumulator
    cycles_t    digit_val;
    logic       is_digit;
    logic       is_lf;

    assign is_digit  = (rx_data >= CHAR_ZERO) && (rx_data <= CHAR_NINE);
    assign is_lf     = (rx_data == CHAR_LF);
    assign digit_val = cycles_t'(rx_data - CHAR_ZERO);

    // ----------------------------------------------------------------------
    // Command FSM advancing only on a received byte
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            ack_trigger <= 1'b0;
        end else begin
            ack_trigger <= 1'b0;
            if (rx_valid) begin
                case (state)
                    ST_IDLE: begin
                        if (rx_data == CHAR_A) begin
                            state <= ST_A;
                        end
                    end
                    ST_A: begin
                        state <= (rx_data == CHAR_C) ? ST_C : ST_IDLE;
                    end
                    ST_C: begin
                        state <= (rx_data == CHAR_K) ? ST_K : ST_IDLE;
                    end
                    ST_K: begin
                        state <= (rx_data == CHAR_SPACE) ? ST_SPACE : ST_IDLE;
                    end
                    ST_SPACE, ST_NUM: begin
                        if (is_digit) begin
                            state <= ST_NUM;
                        end else begin
                            ack_trigger <= is_lf;   // Digits are optional
                            state       <= ST_IDLE;
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    // Number and duration registers
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            if (state == ST_IDLE && rx_data == CHAR_A) begin
                ms_value <= '0;     // New command
            end else if ((state == ST_SPACE || state == ST_NUM) && is_digit) begin
                ms_value <= ms_value * cycles_t'(10) + digit_val;
            end
            if ((state == ST_SPACE || state == ST_NUM) && is_lf) begin
                led_cycles <= ms_value * cycles_t'(CYCLES_PER_MS);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/led_pulse.sv ====
// LED timer, holds led high for led_cycles + 1 cycles per trigger
// A new trigger while lit reloads the count

`timescale 1ns/1ns
`default_nettype none

module led_pulse (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ack_trigger,
    input  counter_pkg::cycles_t led_cycles,
    output logic                 led
);
    import counter_pkg::*;

    cycles_t remaining;     // Cycles left after the current one

    always_ff @(posedge clk) begin
        if (rst) begin
            remaining <= '0;
            led       <= 1'b0;
        end else if (ack_trigger) begin
            remaining <= led_cycles;    // Restart timer
            led       <= 1'b1;
        end else if (remaining != '0) begin
            remaining <= remaining - 1'b1;
            led       <= 1'b1;
        end else begin
            led <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/super_counter.sv ====
// Push-button counter top level
// Button path to the outputs, serial ACK commands drive the LED timer

`timescale 1ns/1ns
`default_nettype none

module super_counter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      btn,
    input  logic                      rx,
    output logic                      led,
    output logic                      btn_level,
    output logic                      btn_pulse,
    output counter_pkg::press_count_t press_count
);
    import counter_pkg::*;

    byte_t   rx_data;
    logic    rx_valid;
    logic    ack_trigger;
    cycles_t led_cycles;

    // ----------------------------------------------------------------------
    // Button path
    // ----------------------------------------------------------------------
    button_counter button_i (
        .clk         (clk),
        .rst         (rst),
        .btn         (btn),
        .btn_level   (btn_level),
        .btn_pulse   (btn_pulse),
        .press_count (press_count)
    );

    // ----------------------------------------------------------------------
    // Serial command path
    // ----------------------------------------------------------------------
    // LF strobe to led rise takes 2 cycles
    uart_rx uart_rx_i (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    ack_parser ack_parser_i (
        .clk         (clk),
        .rst         (rst),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .ack_trigger (ack_trigger),
        .led_cycles  (led_cycles)
    );

    led_pulse led_pulse_i (
        .clk         (clk),
        .rst         (rst),
        .ack_trigger (ack_trigger),
        .led_cycles  (led_cycles),
        .led         (led)
    );

endmodule

`default_nettype wire

// ==== bench/super_counter_assertions.sv ====
// Concurrent checks on the push-button counter top level
// Bound into super_counter, parser state taken from the parser instance

`timescale 1ns/1ns
`default_nettype none

module super_counter_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    led,
    input logic                    btn_level,
    input logic                    btn_pulse,
    input counter_pkg::ack_state_t parser_state
);
    import counter_pkg::*;

    // One pulse per press, never stretched
    pulse_single: assert property (@(posedge clk) disable iff (rst) btn_pulse |=> !btn_pulse)
        else $error("btn_pulse high on two consecutive cycles");

    pulse_level: assert property (@(posedge clk) disable iff (rst) btn_pulse |-> btn_level)
        else $error("btn_pulse without debounced level");

    // Covers the reset cycles and the first cycle after reset
    led_reset: assert property (@(posedge clk) rst |=> !led)
        else $error("led high during or right after reset");

    state_legal: assert property (@(posedge clk) disable iff (rst)
            parser_state inside {ST_IDLE, ST_A, ST_C, ST_K, ST_SPACE, ST_NUM})
        else $error("parser in an illegal state");

endmodule

bind super_counter super_counter_assertions assertions_i (
    .clk          (clk),
    .rst          (rst),
    .led          (led),
    .btn_level    (btn_level),
    .btn_pulse    (btn_pulse),
    .parser_state (ack_parser_i.state)
);

`default_nettype wire

// ==== bench/tb_super_counter.sv ====
// Testbench for the push-button counter
// Steps from a data file drive bounced presses and serial ACK commands

`timescale 1ns/1ns
`default_nettype none

module tb_super_counter;
    import counter_pkg::*;

    localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT;  // Start, 8 data, stop
    localparam int PRESS_CYCLES = 64;                 // Bound on one bounced press
    localparam int STEP_MARGIN  = 100;

    logic         clk;
    logic         rst;
    logic         btn;
    logic         rx;
    logic         led;
    logic         btn_level;
    logic         btn_pulse;
    press_count_t press_count;

    int   seed      = 32'h5b32adab;
    int   cycle     = 0;                // Rising edges since time zero
    int   limit     = 4 + STEP_MARGIN;  // Grows with each step read
    int   led_high  = 0;                // Running totals, steps take differences
    int   led_falls = 0;
    int   pulses    = 0;
    logic led_q     = 1'b0;

    super_counter dut_i (
        .clk         (clk),
        .rst         (rst),
        .btn         (btn),
        .rx          (rx),
        .led         (led),
        .btn_level   (btn_level),
        .btn_pulse   (btn_pulse),
        .press_count (press_count)
    );

    always #20 clk = ~clk;  // 40 ns period

    // ----------------------------------------------------------------------
    // Edge monitor and watchdog
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (led) begin
            led_high = led_high + 1;    // One per cycle lit
        end
        if (led_q && !led) begin
            led_falls = led_falls + 1;
        end
        led_q = led;
        if (btn_pulse) begin
            pulses = pulses + 1;
        end
        if (cycle > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("** FAIL **");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;                             // Drive just after the edge
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    // 8N1 frame, LSB first
    task automatic send_byte(input byte_t data);
        int i;
        rx = 1'b0;
        wait_cycles(CLKS_PER_BIT);
        for (i = 0; i < 8; i++) begin
            rx = data[i];
            wait_cycles(CLKS_PER_BIT);
        end
        rx = 1'b1;                      // Stop bit
        wait_cycles(CLKS_PER_BIT);
    endtask

    task automatic send_number(input int value);
        byte_t digits[$];
        int    v;
        v = value;
        do begin
            digits.push_front(CHAR_ZERO + byte_t'(v % 10));  // Most significant first
            v = v / 10;
        end while (v > 0);
        foreach (digits[i]) begin
            send_byte(digits[i]);
        end
    endtask

    task automatic send_ack(input int ms, input bit with_digits);
        send_byte(CHAR_A);
        send_byte(CHAR_C);
        send_byte(CHAR_K);
        send_byte(CHAR_SPACE);
        if (with_digits) begin
            send_number(ms);
        end
        send_byte(CHAR_LF);
    endtask

    // Kind 0 has a wrong letter, kind 1 lacks the space
    task automatic send_bad(input int kind);
        send_byte(CHAR_A);
        send_byte(CHAR_C);
        send_byte(kind == 0 ? 8'h58 : CHAR_K);
        if (kind == 0) begin
            send_byte(CHAR_SPACE);
        end
        send_number(5);
        send_byte(CHAR_LF);
    endtask

    // Short glitches around the new level, then a long settled hold
    task automatic bounce_to(input logic level);
        int k;
        int w;
        for (k = 0; k < 3; k++) begin
            w = 1 + ($unsigned($random(seed)) % (DEBOUNCE_CYCLES - 1));
            btn = level;
            wait_cycles(w);
            w = 1 + ($unsigned($random(seed)) % (DEBOUNCE_CYCLES - 1));
            btn = ~level;
            wait_cycles(w);
        end
        btn = level;
        wait_cycles(3 * DEBOUNCE_CYCLES);
    endtask

    task automatic press_button();
        bounce_to(1'b1);
        bounce_to(1'b0);
    endtask

    task automatic wait_led_off(input int falls_base);
        while (led_falls == falls_base) begin
            next_cycle();
        end
    endtask

    // Cycle budget of one data line
    function automatic int step_budget(input byte_t step, input int arg, input int expected);
        if (step == "P") begin
            return arg * PRESS_CYCLES + STEP_MARGIN;
        end
        return 16 * FRAME_CYCLES + expected + STEP_MARGIN;  // Two 8-byte commands at most
    endfunction

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        int    fd;
        int    n;
        int    arg;
        int    expected;
        int    done_first;
        int    done_second;
        int    high_base;
        int    falls_base;
        int    pulse_base;
        byte_t step;
        string line;

        clk = 1'b0;
        rst = 1'b1;
        btn = 1'b0;
        rx  = 1'b1;                     // Serial line idles high
        fd  = $fopen("bench/super_counter_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            $display("** FAIL **");
            $fatal(1, "missing test data");
        end
        wait_cycles(4);
        rst = 1'b0;

        check_value("led", 32'(led), 0);
        check_value("btn_pulse", 32'(btn_pulse), 0);
        check_value("btn_level", 32'(btn_level), 0);
        check_value("press_count", 32'(press_count), 0);

        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() == 0 || line[0] == "#") begin
                continue;               // Comment or end of file
            end
            n = $sscanf(line, "%c %d %d", step, arg, expected);
            if (n != 3) begin
                continue;
            end
            limit      = limit + step_budget(step, arg, expected);
            high_base  = led_high;
            falls_base = led_falls;
            pulse_base = pulses;
            case (step)
                "P": begin
                    repeat (arg) press_button();
                    check_value("btn_pulse count", pulses - pulse_base, arg);
                    check_value("press_count", 32'(press_count), expected);
                end
                "A", "Z": begin
                    send_ack(arg, step == "A");
                    wait_led_off(falls_base);
                    check_value("led high cycles", led_high - high_base, expected);
                end
                "X": begin
                    send_bad(arg);
                    wait_cycles(FRAME_CYCLES);  // Window where a pulse would show
                    check_value("led high cycles", led_high - high_base, expected);
                end
                "R": begin
                    send_ack(arg, 1'b1);
                    done_first = cycle;
                    send_ack(arg, 1'b1);
                    done_second = cycle;
                    check_value("led falls before restart", led_falls - falls_base, 0);
                    // Both LF strobes sit at the same point of their frames
                    // Rise to rise equals send end to send end
                    wait_led_off(falls_base);
                    check_value("led high cycles", led_high - high_base,
                                (done_second - done_first) + expected);
                end
                default: begin
                    $display("Unknown step letter in the test data file");
                    $display("** FAIL **");
                    $fatal(1, "bad test data");
                end
            endcase
        end
        $fclose(fd);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/super_counter_testdata.txt ====
# step arg expected: P presses/running count, A ms/led cycles, X kind/led cycles
# Z sends ACK with no digits, R sends ACK arg twice and expects the second duration
P 1 1
P 3 4
A 0 1
A 2 17
A 5 41
X 0 0
X 1 0
Z 0 1
P 2 6
A 12 97
R 200 1601
A 1 9

// ==== all.f ====
common/counter_pkg.sv
hw/button/button_counter.sv
hw/uart/uart_rx.sv
hw/ack_parser.sv
hw/led_pulse.sv
hw/super_counter.sv
bench/super_counter_assertions.sv
bench/tb_super_counter.sv

// ==== Makefile ====
# Verilator build and run for the push-button counter

VERILATOR ?= verilator
TOP       ?= tb_super_counter
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
